// ==== writeback_top.f ====
source/wb_pkg.sv
source/writeback_stage.sv
source/arch_reg_file.sv
source/store_queue.sv
source/writeback_top.sv
tests/writeback_top_chk.sv
tests/writeback_top_tb.sv

// ==== tests/writeback_top_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module writeback_top_tb;

    localparam int SQ_DEPTH   = 4;
    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        logic        stall;
        logic        valid_out;
        logic        push;
        logic [31:0] st_addr;
        logic [63:0] st_data;
        logic [1:0]  st_size;
        logic [31:0] new_eip;
        logic        is_resteer;
        logic        ie_val;
        logic [3:0]  ie_type;
        logic        halt;
    } stage_exp_t;

    logic clk;
    logic rst;
    logic valid_in;
    logic [3:0][63:0] slot_data;
    logic [3:0][31:0] slot_dest;
    logic [3:0] slot_is_reg;
    logic [3:0] slot_is_seg;
    logic [3:0] slot_is_mem;
    logic [3:0] slot_wb;
    wb_pkg::size_t res_size;
    logic far_xfer;
    logic halt_op;
    logic [31:0] eip_in;
    logic br_valid_in;
    logic br_taken_in;
    logic br_correct_in;
    logic [31:0] br_target_in;
    logic ie_in;
    logic [3:0] ie_type_in;
    logic interrupt_in;
    logic mem_wr_valid;
    logic [31:0] mem_wr_addr;
    logic [63:0] mem_wr_data;
    wb_pkg::size_t mem_wr_size;
    logic mem_ready;
    logic [2:0] gpr_rd_addr;
    wb_pkg::gpr_t gpr_rd_data;
    logic [2:0] seg_rd_addr;
    wb_pkg::seg_t seg_rd_data;
    logic valid_out;
    logic stall;
    logic [31:0] new_eip;
    logic is_resteer;
    logic final_ie_val;
    logic [3:0] final_ie_type;
    logic halt;

    wb_pkg::gpr_t gpr_shadow [8];
    wb_pkg::seg_t seg_shadow [8];
    logic [97:0] exp_st [$]; // {addr, data, size}
    int sq_count;
    int seed;
    int ready_mode; // 0 random, 1 held low, 2 held high
    int errors;
    int errors_base;
    int tests_run;
    int tests_failed;
    bit timed_out;

    always #10 clk = ~clk;

    writeback_top #(.SQ_DEPTH(SQ_DEPTH)) i_dut (.*);

    function automatic stage_exp_t expect_stage(logic full);
        stage_exp_t e;
        logic found;
        logic [31:0] target;
        e = '0;
        found = 1'b0;
        for (int s = 0; s < 4; s++) begin
            if (!found && valid_in && slot_wb[s] && slot_is_mem[s]) begin
                found = 1'b1; // lowest store slot
                e.st_addr = slot_dest[s];
                e.st_data = slot_data[s];
            end
        end
        e.stall = valid_in && found && full;
        e.valid_out = valid_in && !e.stall;
        e.push = found && e.valid_out;
        e.st_size = far_xfer ? wb_pkg::SIZE_FAR : res_size;
        target = far_xfer ? slot_data[1][31:0] : br_target_in;
        e.new_eip = br_taken_in ? target : eip_in;
        e.is_resteer = e.valid_out && !br_correct_in;
        e.ie_val = ie_in || interrupt_in;
        e.ie_type = {interrupt_in, ie_type_in[2:0]};
        e.halt = halt_op && valid_in;
        return e;
    endfunction

    task automatic report_mismatch(string name, logic [63:0] exp_val, logic [63:0] got_val);
        errors++;
        $display("ERR %0t %s exp %h got %h", $time, name, exp_val, got_val);
    endtask

    always @(negedge clk) begin : compare
        stage_exp_t e;
        logic [97:0] st;
        logic [63:0] val;
        if (rst) begin
            for (int r = 0; r < 8; r++) begin
                gpr_shadow[r] = '0;
                seg_shadow[r] = '0;
            end
            exp_st.delete();
            sq_count = 0;
        end else begin
            assert (gpr_rd_data === gpr_shadow[gpr_rd_addr])
                else report_mismatch("gpr_rd_data", gpr_shadow[gpr_rd_addr], gpr_rd_data);
            assert (seg_rd_data === seg_shadow[seg_rd_addr])
                else report_mismatch("seg_rd_data", seg_shadow[seg_rd_addr], seg_rd_data);
            e = expect_stage(sq_count == SQ_DEPTH);
            assert (stall === e.stall) else report_mismatch("stall", e.stall, stall);
            assert (valid_out === e.valid_out)
                else report_mismatch("valid_out", e.valid_out, valid_out);
            assert (new_eip === e.new_eip) else report_mismatch("new_eip", e.new_eip, new_eip);
            assert (is_resteer === e.is_resteer)
                else report_mismatch("is_resteer", e.is_resteer, is_resteer);
            assert (final_ie_val === e.ie_val)
                else report_mismatch("final_ie_val", e.ie_val, final_ie_val);
            assert (final_ie_type === e.ie_type)
                else report_mismatch("final_ie_type", e.ie_type, final_ie_type);
            assert (halt === e.halt) else report_mismatch("halt", e.halt, halt);
            assert (mem_wr_valid === (sq_count != 0))
                else report_mismatch("mem_wr_valid", sq_count != 0, mem_wr_valid);
            if (sq_count != 0 && mem_ready) begin // transfer at the coming edge
                st = exp_st.pop_front();
                assert (mem_wr_addr === st[97:66])
                    else report_mismatch("mem_wr_addr", st[97:66], mem_wr_addr);
                assert (mem_wr_data === st[65:2])
                    else report_mismatch("mem_wr_data", st[65:2], mem_wr_data);
                assert (mem_wr_size === st[1:0])
                    else report_mismatch("mem_wr_size", st[1:0], mem_wr_size);
                sq_count--;
            end
            if (e.push) begin
                exp_st.push_back({e.st_addr, e.st_data, e.st_size});
                sq_count++;
            end
            if (e.valid_out) begin
                for (int s = 0; s < 4; s++) begin // ascending, so higher slot wins
                    val = (far_xfer && s == 1) ? {48'h0, slot_data[1][47:32]} : slot_data[s];
                    if (slot_wb[s] && slot_is_reg[s]) begin
                        gpr_shadow[slot_dest[s][2:0]] = val[31:0];
                    end
                    if (slot_wb[s] && slot_is_seg[s]) begin
                        seg_shadow[slot_dest[s][2:0]] = val[15:0];
                    end
                end
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (ready_mode == 1) begin
            mem_ready = 1'b0;
        end else if (ready_mode == 2) begin
            mem_ready = 1'b1;
        end else begin
            mem_ready = ($random(seed) & 3) != 0; // withheld a quarter of the time
        end
    endtask

    task automatic idle_inputs();
        valid_in = 1'b0;
        slot_data = '0;
        slot_dest = '0;
        slot_is_reg = '0;
        slot_is_seg = '0;
        slot_is_mem = '0;
        slot_wb = '0;
        res_size = '0;
        far_xfer = 1'b0;
        halt_op = 1'b0;
        eip_in = '0;
        br_valid_in = 1'b0;
        br_taken_in = 1'b0;
        br_correct_in = 1'b1;
        br_target_in = '0;
        ie_in = 1'b0;
        ie_type_in = '0;
        interrupt_in = 1'b0;
        gpr_rd_addr = '0;
        seg_rd_addr = '0;
    endtask

    task automatic random_instr(bit with_store, bit with_far);
        for (int s = 0; s < 4; s++) begin
            slot_data[s] = {$random(seed), $random(seed)};
            slot_dest[s] = $random(seed);
        end
        valid_in = ($random(seed) & 7) != 0;
        slot_is_reg = $random(seed);
        slot_is_seg = $random(seed);
        slot_wb = $random(seed);
        slot_is_mem = with_store ? 4'b0001 << ($random(seed) & 3) : 4'b0000;
        res_size = $random(seed);
        far_xfer = with_far;
        halt_op = ($random(seed) & 7) == 0;
        eip_in = $random(seed);
        br_valid_in = $random(seed);
        br_taken_in = $random(seed);
        br_correct_in = $random(seed);
        br_target_in = $random(seed);
        ie_in = $random(seed);
        ie_type_in = $random(seed);
        interrupt_in = $random(seed);
        gpr_rd_addr = $random(seed);
        seg_rd_addr = $random(seed);
    endtask

    task automatic store_instr();
        random_instr(1'b1, 1'b0);
        valid_in = 1'b1;
        slot_wb = slot_wb | slot_is_mem;
    endtask

    // hold the inputs until the stage accepts them
    task automatic retire_one();
        int waited;
        waited = 0;
        @(negedge clk);
        while (stall && !timed_out) begin
            if (waited == WAIT_LIMIT) begin
                timed_out = 1'b1;
                $display("timeout: stall stayed high for %0d cycles", WAIT_LIMIT);
            end else begin
                waited++;
                next_cycle();
                @(negedge clk);
            end
        end
        next_cycle();
    endtask

    task automatic drain_stores();
        int waited;
        waited = 0;
        idle_inputs();
        ready_mode = 0;
        while ((exp_st.size() != 0 || mem_wr_valid) && !timed_out) begin
            if (waited == WAIT_LIMIT) begin
                timed_out = 1'b1;
                $display("timeout: store queue did not drain in %0d cycles", WAIT_LIMIT);
            end else begin
                waited++;
                next_cycle();
            end
        end
    endtask

    task automatic readback_all();
        idle_inputs();
        for (int r = 0; r < 8; r++) begin
            gpr_rd_addr = r;
            seg_rd_addr = 7 - r;
            next_cycle();
        end
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (errors != errors_base || timed_out) begin
            tests_failed++;
            $display("test %s: FAIL, %0d errors", name, errors - errors_base);
        end else begin
            $display("test %s: ok", name);
        end
        errors_base = errors;
    endtask

    initial begin : stimulus
        seed = 32'hcd28_3377;
        clk = 1'b0;
        rst = 1'b1;
        mem_ready = 1'b0;
        ready_mode = 0;
        errors = 0;
        errors_base = 0;
        tests_run = 0;
        tests_failed = 0;
        timed_out = 1'b0;
        idle_inputs();
        repeat (4) next_cycle();
        rst = 1'b0;

        repeat (60) begin
            random_instr(1'b0, 1'b0);
            retire_one();
        end
        readback_all();
        end_test("register writes");

        repeat (60) begin
            random_instr(1'b1, 1'b0);
            retire_one();
        end
        drain_stores();
        end_test("store order");

        drain_stores();
        ready_mode = 1;
        for (int k = 0; k < SQ_DEPTH; k++) begin
            store_instr();
            retire_one();
        end
        store_instr();
        @(negedge clk);
        assert (stall === 1'b1) else begin
            errors++;
            $display("stall stayed low for a store into a full queue");
        end
        // sweep both files while stalled, nothing may change
        for (int r = 0; r < 8; r++) begin
            next_cycle();
            gpr_rd_addr = r;
            seg_rd_addr = r;
        end
        ready_mode = 2;
        retire_one();
        drain_stores();
        end_test("stall");

        repeat (20) begin
            random_instr(1'b1, 1'b1);
            valid_in = 1'b1;
            slot_is_seg[1] = 1'b1;
            slot_wb[1] = 1'b1;
            br_taken_in = 1'b1;
            retire_one();
        end
        drain_stores();
        readback_all();
        end_test("far transfer");

        repeat (40) begin
            random_instr(1'b0, $random(seed) & 1);
            retire_one();
        end
        end_test("branch resteer");

        repeat (40) begin
            random_instr(1'b0, 1'b0);
            retire_one();
        end
        end_test("exception merge");

        $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, errors, i_dut.i_chk.fail_count);
        if (errors == 0 && i_dut.i_chk.fail_count == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/writeback_top_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module writeback_top_chk (
    input logic                      clk,
    input logic                      rst,
    input logic                      st_push,
    input logic                      sq_full,
    input logic                      stall,
    input logic                      valid_out,
    input logic                      mem_wr_valid,
    input logic [wb_pkg::ADDR_W-1:0] mem_wr_addr,
    input logic [wb_pkg::SLOT_W-1:0] mem_wr_data,
    input wb_pkg::size_t             mem_wr_size,
    input logic                      mem_ready
);

    int fail_count = 0; // assertion failures so far

    no_push_full: assert property (@(posedge clk) disable iff (rst) !(st_push && sq_full))
        else begin
            $error("store pushed into a full queue");
            fail_count++;
        end

    empty_after_rst: assert property (@(posedge clk) rst |=> !mem_wr_valid)
        else begin
            $error("memory write valid high right after reset");
            fail_count++;
        end

    stall_blocks: assert property (@(posedge clk) disable iff (rst) stall |-> !valid_out)
        else begin
            $error("valid_out high during a stall");
            fail_count++;
        end

    // head entry must hold under back-pressure
    head_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_wr_valid && !mem_ready) |=> (mem_wr_valid && $stable(mem_wr_addr)
            && $stable(mem_wr_data) && $stable(mem_wr_size)))
        else begin
            $error("store queue head changed while memory held it off");
            fail_count++;
        end

endmodule

bind writeback_top writeback_top_chk i_chk (
    .clk          (clk),
    .rst          (rst),
    .st_push      (st_push),
    .sq_full      (sq_full),
    .stall        (stall),
    .valid_out    (valid_out),
    .mem_wr_valid (mem_wr_valid),
    .mem_wr_addr  (mem_wr_addr),
    .mem_wr_data  (mem_wr_data),
    .mem_wr_size  (mem_wr_size),
    .mem_ready    (mem_ready)
);

`default_nettype wire

// ==== source/writeback_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module writeback_top #(
    parameter int SQ_DEPTH = 4
) (
    input  logic                                             clk,
    input  logic                                             rst,

    input  logic                                             valid_in,
    input  logic [wb_pkg::NUM_SLOTS-1:0][wb_pkg::SLOT_W-1:0] slot_data,
    input  logic [wb_pkg::NUM_SLOTS-1:0][wb_pkg::ADDR_W-1:0] slot_dest,
    input  logic [wb_pkg::NUM_SLOTS-1:0]                     slot_is_reg,
    input  logic [wb_pkg::NUM_SLOTS-1:0]                     slot_is_seg,
    input  logic [wb_pkg::NUM_SLOTS-1:0]                     slot_is_mem,
    input  logic [wb_pkg::NUM_SLOTS-1:0]                     slot_wb,
    input  wb_pkg::size_t                                    res_size,
    input  logic                                             far_xfer,
    input  logic                                             halt_op,

    input  logic [31:0]                                      eip_in,
    input  logic                                             br_valid_in,
    input  logic                                             br_taken_in,
    input  logic                                             br_correct_in,
    input  logic [31:0]                                      br_target_in,
    input  logic                                             ie_in,
    input  logic [3:0]                                       ie_type_in,
    input  logic                                             interrupt_in,

    output logic                                             mem_wr_valid,
    output logic [wb_pkg::ADDR_W-1:0]                        mem_wr_addr,
    output logic [wb_pkg::SLOT_W-1:0]                        mem_wr_data,
    output wb_pkg::size_t                                    mem_wr_size,
    input  logic                                             mem_ready,

    input  logic [wb_pkg::REG_IDX_W-1:0]                     gpr_rd_addr,
    output wb_pkg::gpr_t                                     gpr_rd_data,
    input  logic [wb_pkg::REG_IDX_W-1:0]                     seg_rd_addr,
    output wb_pkg::seg_t                                     seg_rd_data,

    output logic                                             valid_out,
    output logic                                             stall,
    output logic [31:0]                                      new_eip,
    output logic                                             is_resteer,
    output logic                                             final_ie_val,
    output logic [3:0]                                       final_ie_type,
    output logic                                             halt
);

    logic [wb_pkg::NUM_SLOTS-1:0]                        gpr_ld;
    logic [wb_pkg::NUM_SLOTS-1:0]                        seg_ld;
    logic [wb_pkg::NUM_SLOTS-1:0][wb_pkg::SLOT_W-1:0]    wr_data;
    logic [wb_pkg::NUM_SLOTS-1:0][wb_pkg::REG_IDX_W-1:0] wr_idx;
    wb_pkg::gpr_t [wb_pkg::NUM_SLOTS-1:0]                gpr_wr_data;
    wb_pkg::seg_t [wb_pkg::NUM_SLOTS-1:0]                seg_wr_data;
    logic                                                st_push;
    logic [wb_pkg::ADDR_W-1:0]                           st_addr;
    logic [wb_pkg::SLOT_W-1:0]                           st_data;
    wb_pkg::size_t                                       st_size;
    logic                                                sq_full;

    writeback_stage u_stage (
        .valid_in      (valid_in),
        .slot_data     (slot_data),
        .slot_dest     (slot_dest),
        .slot_is_reg   (slot_is_reg),
        .slot_is_seg   (slot_is_seg),
        .slot_is_mem   (slot_is_mem),
        .slot_wb       (slot_wb),
        .res_size      (res_size),
        .far_xfer      (far_xfer),
        .halt_op       (halt_op),
        .eip_in        (eip_in),
        .br_taken_in   (br_taken_in),
        .br_correct_in (br_correct_in),
        .br_target_in  (br_target_in),
        .ie_in         (ie_in),
        .ie_type_in    (ie_type_in),
        .interrupt_in  (interrupt_in),
        .sq_full       (sq_full),
        .valid_out     (valid_out),
        .stall         (stall),
        .gpr_ld        (gpr_ld),
        .seg_ld        (seg_ld),
        .wr_data       (wr_data),
        .wr_idx        (wr_idx),
        .st_push       (st_push),
        .st_addr       (st_addr),
        .st_data       (st_data),
        .st_size       (st_size),
        .new_eip       (new_eip),
        .is_resteer    (is_resteer),
        .final_ie_val  (final_ie_val),
        .final_ie_type (final_ie_type),
        .halt          (halt)
    );

    // each file takes the low bits of the slot payload
    for (genvar s = 0; s < wb_pkg::NUM_SLOTS; s++) begin : g_wr_slice
        assign gpr_wr_data[s] = wr_data[s][$bits(wb_pkg::gpr_t)-1:0];
        assign seg_wr_data[s] = wr_data[s][$bits(wb_pkg::seg_t)-1:0];
    end

    arch_reg_file #(
        .entry_t (wb_pkg::gpr_t)
    ) u_gpr (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (gpr_ld),
        .wr_idx  (wr_idx),
        .wr_data (gpr_wr_data),
        .rd_idx  (gpr_rd_addr),
        .rd_data (gpr_rd_data)
    );

    arch_reg_file #(
        .entry_t (wb_pkg::seg_t)
    ) u_seg (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (seg_ld),
        .wr_idx  (wr_idx),
        .wr_data (seg_wr_data),
        .rd_idx  (seg_rd_addr),
        .rd_data (seg_rd_data)
    );

    store_queue #(
        .SQ_DEPTH (SQ_DEPTH)
    ) u_sq (
        .clk          (clk),
        .rst          (rst),
        .push         (st_push),
        .push_addr    (st_addr),
        .push_data    (st_data),
        .push_size    (st_size),
        .full         (sq_full),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_data  (mem_wr_data),
        .mem_wr_size  (mem_wr_size),
        .mem_ready    (mem_ready)
    );

endmodule

`default_nettype wire

// ==== source/store_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module store_queue #(
    parameter int SQ_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      push,
    input  logic [wb_pkg::ADDR_W-1:0] push_addr,
    input  logic [wb_pkg::SLOT_W-1:0] push_data,
    input  wb_pkg::size_t             push_size,
    output logic                      full,

    // drain to data memory
    output logic                      mem_wr_valid,
    output logic [wb_pkg::ADDR_W-1:0] mem_wr_addr,
    output logic [wb_pkg::SLOT_W-1:0] mem_wr_data,
    output wb_pkg::size_t             mem_wr_size,
    input  logic                      mem_ready
);

    localparam int PTR_W = $clog2(SQ_DEPTH);

    logic [wb_pkg::ADDR_W-1:0] addr_mem [SQ_DEPTH];
    logic [wb_pkg::SLOT_W-1:0] data_mem [SQ_DEPTH];
    wb_pkg::size_t             size_mem [SQ_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic [PTR_W:0]   count_nxt;
    logic             push_ok;
    logic             pop;

    assign push_ok = push & ~full; // drop on full
    assign pop     = mem_wr_valid & mem_ready;

    always_comb begin
        count_nxt = count;
        if (push_ok && !pop) begin
            count_nxt = count + 1'b1;
        end else if (!push_ok && pop) begin
            count_nxt = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_nxt;
            full  <= (count_nxt == (PTR_W + 1)'(SQ_DEPTH));
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            addr_mem[wr_ptr] <= push_addr;
            data_mem[wr_ptr] <= push_data;
            size_mem[wr_ptr] <= push_size;
        end
    end

    // head entry held until memory takes it
    assign mem_wr_valid = (count != '0);
    assign mem_wr_addr  = addr_mem[rd_ptr];
    assign mem_wr_data  = data_mem[rd_ptr];
    assign mem_wr_size  = size_mem[rd_ptr];

endmodule

`default_nettype wire

// ==== source/arch_reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module arch_reg_file #(
    parameter type entry_t = logic [31:0]
) (
    input  logic                                                clk,
    input  logic                                                rst,

    input  logic [wb_pkg::NUM_SLOTS-1:0]                        wr_en,
    input  logic [wb_pkg::NUM_SLOTS-1:0][wb_pkg::REG_IDX_W-1:0] wr_idx,
    input  entry_t [wb_pkg::NUM_SLOTS-1:0]                      wr_data,

    input  logic [wb_pkg::REG_IDX_W-1:0]                        rd_idx,
    output entry_t                                              rd_data
);

    entry_t regs     [wb_pkg::NUM_REGS];
    entry_t regs_nxt [wb_pkg::NUM_REGS];

    // per-entry write resolution, higher slot overrides
    always_comb begin
        for (int e = 0; e < wb_pkg::NUM_REGS; e++) begin
            regs_nxt[e] = regs[e];
            for (int s = 0; s < wb_pkg::NUM_SLOTS; s++) begin
                if (wr_en[s] && (wr_idx[s] == wb_pkg::REG_IDX_W'(e))) begin
                    regs_nxt[e] = wr_data[s];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int e = 0; e < wb_pkg::NUM_REGS; e++) begin
                regs[e] <= '0; // architectural state starts clear
            end
        end else begin
            for (int e = 0; e < wb_pkg::NUM_REGS; e++) begin
                regs[e] <= regs_nxt[e];
            end
        end
    end

    assign rd_data = regs[rd_idx]; // async read

endmodule

`default_nettype wire

// ==== source/writeback_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module writeback_stage (
    // retiring instruction
    input  logic                                                   valid_in,
    input  logic [wb_pkg::NUM_SLOTS-1:0][wb_pkg::SLOT_W-1:0]       slot_data,
    input  logic [wb_pkg::NUM_SLOTS-1:0][wb_pkg::ADDR_W-1:0]       slot_dest,
    input  logic [wb_pkg::NUM_SLOTS-1:0]                           slot_is_reg,
    input  logic [wb_pkg::NUM_SLOTS-1:0]                           slot_is_seg,
    input  logic [wb_pkg::NUM_SLOTS-1:0]                           slot_is_mem,
    input  logic [wb_pkg::NUM_SLOTS-1:0]                           slot_wb,
    input  wb_pkg::size_t                                          res_size,
    input  logic                                                   far_xfer,
    input  logic                                                   halt_op,

    // branch and exception state
    input  logic [31:0]                                            eip_in,
    input  logic                                                   br_taken_in,
    input  logic                                                   br_correct_in,
    input  logic [31:0]                                            br_target_in,
    input  logic                                                   ie_in,
    input  logic [3:0]                                             ie_type_in,
    input  logic                                                   interrupt_in,

    input  logic                                                   sq_full,

    output logic                                                   valid_out,
    output logic                                                   stall,

    // register file write ports
    output logic [wb_pkg::NUM_SLOTS-1:0]                           gpr_ld,
    output logic [wb_pkg::NUM_SLOTS-1:0]                           seg_ld,
    output logic [wb_pkg::NUM_SLOTS-1:0][wb_pkg::SLOT_W-1:0]       wr_data,
    output logic [wb_pkg::NUM_SLOTS-1:0][wb_pkg::REG_IDX_W-1:0]    wr_idx,

    // store queue push
    output logic                                                   st_push,
    output logic [wb_pkg::ADDR_W-1:0]                              st_addr,
    output logic [wb_pkg::SLOT_W-1:0]                              st_data,
    output wb_pkg::size_t                                          st_size,

    output logic [31:0]                                            new_eip,
    output logic                                                   is_resteer,
    output logic                                                   final_ie_val,
    output logic [3:0]                                             final_ie_type,
    output logic                                                   halt
);

    localparam int SEL_W    = $clog2(wb_pkg::NUM_SLOTS);
    localparam int FAR_SLOT = 1; // selector and offset ride here

    logic [wb_pkg::NUM_SLOTS-1:0] st_req;
    logic                         st_any;
    logic [SEL_W-1:0]             st_slot;
    logic [31:0]                  br_target;

    // stores requested by this instruction, before the stall
    assign st_req = slot_is_mem & slot_wb & {wb_pkg::NUM_SLOTS{valid_in}};
    assign st_any = |st_req;

    assign stall     = st_any & sq_full;
    assign valid_out = valid_in & ~stall;

    assign gpr_ld = slot_is_reg & slot_wb & {wb_pkg::NUM_SLOTS{valid_out}};
    assign seg_ld = slot_is_seg & slot_wb & {wb_pkg::NUM_SLOTS{valid_out}};

    // lowest store slot wins
    always_comb begin
        st_slot = '0;
        for (int s = wb_pkg::NUM_SLOTS - 1; s >= 0; s--) begin
            if (st_req[s]) begin
                st_slot = SEL_W'(s);
            end
        end
    end

    assign st_push = st_any & valid_out;
    assign st_addr = slot_dest[st_slot];
    assign st_data = slot_data[st_slot];
    assign st_size = far_xfer ? wb_pkg::SIZE_FAR : res_size;

    // register write payloads, slot 1 carries the selector on a far jump
    always_comb begin
        for (int s = 0; s < wb_pkg::NUM_SLOTS; s++) begin
            wr_data[s] = slot_data[s];
            wr_idx[s]  = slot_dest[s][wb_pkg::REG_IDX_W-1:0];
        end
        if (far_xfer) begin
            wr_data[FAR_SLOT] = {{(wb_pkg::SLOT_W - 16){1'b0}},
                                 slot_data[FAR_SLOT][47:32]};
        end
    end

    // far target is the offset in slot 1
    assign br_target = far_xfer ? slot_data[FAR_SLOT][31:0] : br_target_in;
    assign new_eip   = br_taken_in ? br_target : eip_in;

    assign is_resteer = valid_out & ~br_correct_in; // mispredict

    assign final_ie_val  = ie_in | interrupt_in;
    assign final_ie_type = {interrupt_in, ie_type_in[2:0]}; // top bit flags interrupt

    assign halt = halt_op & valid_in;

endmodule

`default_nettype wire

// ==== source/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    // result slots retired per instruction
    localparam int NUM_SLOTS = 4;

    // register file index width, eight entries per file
    localparam int REG_IDX_W = 3;
    localparam int NUM_REGS  = 1 << REG_IDX_W;

    localparam int SLOT_W = 64; // slot payload width
    localparam int ADDR_W = 32; // slot destination and memory address

    // general register, always the low word of a slot
    typedef logic [31:0] gpr_t;

    // segment selector
    typedef logic [15:0] seg_t;

    // store size code
    // 0 byte, 1 half, 2 word, 3 double word
    typedef logic [1:0] size_t;

    // far transfers store selector and offset together
    localparam size_t SIZE_FAR = 2'd3;

endpackage

`default_nettype wire
